// ==== logic/uart_cmd_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shared timing and width constants for the serial command block
////////////////////////////////////////////////////////////////////////////

package uart_cmd_pkg;

	// serial bit timing
	localparam int clk_per_bit = 32;		// clocks per serial bit
	localparam int half_bit = clk_per_bit / 2;	// start bit middle sample point

	// bit period counter width in rx and tx
	localparam int bit_cnt_w = 6;

	// data widths
	localparam int byte_w = 8;			// one serial byte
	localparam int param_w = 16;			// command parameter (two bytes)

endpackage

`default_nettype wire

// ==== logic/uart_rx.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_rx (
	input  logic clk,
	input  logic rst_n,
	input  logic rx,					// serial line from host
	output logic [uart_cmd_pkg::byte_w-1:0] rx_data,	// last byte received
	output logic rx_rdy					// held high after a byte lands
);

	typedef enum logic [1:0] {
		idle,	// line high and waiting for a falling edge
		start,	// recheck start bit at its middle
		data,	// shifting in data bits
		stop	// wait for the stop bit sample
	} rx_state_t;

	rx_state_t state;

	logic rx_meta;					// first sync flop
	logic rx_sync;					// second sync flop
	logic rx_prev;					// delayed copy for edge detect
	logic [uart_cmd_pkg::bit_cnt_w-1:0] cnt;	// clocks within a bit
	logic [2:0] bit_idx;				// data bit number
	logic [uart_cmd_pkg::byte_w-1:0] shreg;	// incoming bits land here
	logic start_edge;
	logic mid_start;
	logic bit_end;

	////////////////////////////////////////////////////////////////////////////
	// synchronize the asynchronous line
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;	// idle line is high
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign start_edge = rx_prev & ~rx_sync;	// high to low on the clean line

	// sample points
	assign mid_start = (cnt == uart_cmd_pkg::bit_cnt_w'(uart_cmd_pkg::half_bit - 1));
	assign bit_end = (cnt == uart_cmd_pkg::bit_cnt_w'(uart_cmd_pkg::clk_per_bit - 1));

	////////////////////////////////////////////////////////////////////////////
	// receive state machine
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			cnt <= '0;
			bit_idx <= '0;
			rx_rdy <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (start_edge) begin
						state <= start;
						cnt <= '0;
						rx_rdy <= 1'b0;	// consumer sees a fresh edge per byte
					end
				end
				start: begin
					if (mid_start) begin
						cnt <= '0;
						bit_idx <= '0;
						// still low at the middle means a real start bit
						state <= rx_sync ? idle : data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				data: begin
					if (bit_end) begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;	// wraps to 0 after bit 7
						if (bit_idx == 3'd7)
							state <= stop;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				stop: begin
					if (bit_end) begin
						rx_rdy <= 1'b1;	// byte complete
						state <= idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// lsb arrives first so shift in from the top
	always_ff @(posedge clk) begin
		if (state == data && bit_end)
			shreg <= {rx_sync, shreg[uart_cmd_pkg::byte_w-1:1]};
		if (state == stop && bit_end)
			rx_data <= shreg;	// load output with the stop sample
	end

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_tx (
	input  logic clk,
	input  logic rst_n,
	input  logic [uart_cmd_pkg::byte_w-1:0] resp,	// byte to send
	input  logic send_resp,				// start strobe
	output logic tx,				// serial line to host
	output logic resp_sent				// high once the frame is out
);

	typedef enum logic {
		idle,	// line parked high
		busy	// frame on the line
	} tx_state_t;

	tx_state_t state;

	logic [uart_cmd_pkg::bit_cnt_w-1:0] cnt;	// clocks within a bit
	logic [3:0] bit_idx;				// frame bit number 0..9
	logic [uart_cmd_pkg::byte_w+1:0] frame;	// stop, data, start
	logic bit_end;
	logic accept;					// send_resp taken
	logic frame_end;				// last clock of the stop bit

	assign accept = (state == idle) & send_resp;	// ignored while busy
	assign bit_end = (cnt == uart_cmd_pkg::bit_cnt_w'(uart_cmd_pkg::clk_per_bit - 1));
	assign frame_end = (state == busy) & bit_end &
		(bit_idx == 4'(uart_cmd_pkg::byte_w + 1));

	assign tx = frame[0];	// lsb of the frame is always on the line

	////////////////////////////////////////////////////////////////////////////
	// frame shifter
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			cnt <= '0;
			bit_idx <= '0;
			frame <= '1;	// keeps tx high
		end else begin
			case (state)
				idle: begin
					if (accept) begin
						frame <= {1'b1, resp, 1'b0};	// start bit goes out next cycle
						cnt <= '0;
						bit_idx <= '0;
						state <= busy;
					end
				end
				busy: begin
					if (bit_end) begin
						cnt <= '0;
						// ones fill in from the top so the line idles high
						frame <= {1'b1, frame[uart_cmd_pkg::byte_w+1:1]};
						if (frame_end)
							state <= idle;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// done flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			resp_sent <= 1'b0;
		else if (accept)
			resp_sent <= 1'b0;	// new frame starting
		else if (frame_end)
			resp_sent <= 1'b1;	// stop bit finished
	end

endmodule

`default_nettype wire

// ==== logic/cmd_assembler.sv ====
`default_nettype none
`timescale 1ns/1ps

module cmd_assembler (
	input  logic clk,
	input  logic rst_n,
	input  logic [uart_cmd_pkg::byte_w-1:0] rx_data,	// byte from receiver
	input  logic rx_rdy,					// level from receiver
	input  logic clr_cmd_rdy,				// host done with command
	output logic [uart_cmd_pkg::byte_w-1:0] cmd,		// opcode
	output logic [uart_cmd_pkg::param_w-1:0] data,	// parameter high byte first
	output logic cmd_rdy					// full command held
);

	typedef enum logic [1:0] {
		get_op,		// waiting for opcode byte
		get_high,	// waiting for parameter high byte
		get_low		// waiting for parameter low byte
	} asm_state_t;

	asm_state_t state, nxt_state;

	logic rx_rdy_q;		// rx_rdy one cycle ago
	logic rdy_rise;		// new byte available
	logic cap_op;		// load opcode
	logic cap_high;		// load data high byte
	logic cap_low;		// load data low byte
	logic set_pend;		// third byte taken last cycle

	////////////////////////////////////////////////////////////////////////////
	// rising edge of rx_rdy
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rx_rdy_q <= 1'b0;
		else
			rx_rdy_q <= rx_rdy;
	end

	assign rdy_rise = rx_rdy & ~rx_rdy_q;

	////////////////////////////////////////////////////////////////////////////
	// byte sequencing
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= get_op;
		else
			state <= nxt_state;
	end

	always_comb begin
		// defaults hold state with no captures
		nxt_state = state;
		cap_op = 1'b0;
		cap_high = 1'b0;
		cap_low = 1'b0;
		case (state)
			get_op: begin
				if (rdy_rise) begin
					cap_op = 1'b1;
					nxt_state = get_high;
				end
			end
			get_high: begin
				if (rdy_rise) begin
					cap_high = 1'b1;
					nxt_state = get_low;
				end
			end
			get_low: begin
				if (rdy_rise) begin
					cap_low = 1'b1;
					nxt_state = get_op;	// back for next command
				end
			end
			default: nxt_state = get_op;
		endcase
	end

	// fields only move on captures so they stay put while cmd_rdy is high
	always_ff @(posedge clk) begin
		if (cap_op)
			cmd <= rx_data;
		if (cap_high)
			data[uart_cmd_pkg::param_w-1:uart_cmd_pkg::byte_w] <= rx_data;
		if (cap_low)
			data[uart_cmd_pkg::byte_w-1:0] <= rx_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// command ready flag
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			set_pend <= 1'b0;
		else
			set_pend <= cap_low;	// one clock after the last capture
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cmd_rdy <= 1'b0;
		else if (set_pend)
			cmd_rdy <= 1'b1;	// set beats clear
		else if (clr_cmd_rdy || cap_op)
			cmd_rdy <= 1'b0;	// host clear or a new opcode overwrites
	end

endmodule

`default_nettype wire

// ==== logic/uart_cmd_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_cmd_top (
	input  logic clk,
	input  logic rst_n,
	input  logic rx,					// serial in from host
	output logic tx,					// serial out to host
	input  logic [uart_cmd_pkg::byte_w-1:0] resp,		// response byte
	input  logic send_resp,					// send the response
	output logic resp_sent,					// response frame finished
	input  logic clr_cmd_rdy,				// host consumed the command
	output logic cmd_rdy,					// command waiting
	output logic [uart_cmd_pkg::byte_w-1:0] cmd,		// opcode
	output logic [uart_cmd_pkg::param_w-1:0] data		// parameter
);

	logic [uart_cmd_pkg::byte_w-1:0] rx_data;	// receiver to assembler
	logic rx_rdy;

	// deframe incoming bytes
	uart_rx u_rx (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx      (rx),
		.rx_data (rx_data),
		.rx_rdy  (rx_rdy)
	);

	// three bytes into one command
	cmd_assembler u_asm (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_data     (rx_data),
		.rx_rdy      (rx_rdy),
		.clr_cmd_rdy (clr_cmd_rdy),
		.cmd         (cmd),
		.data        (data),
		.cmd_rdy     (cmd_rdy)
	);

	// response path straight from the host ports
	uart_tx u_tx (
		.clk       (clk),
		.rst_n     (rst_n),
		.resp      (resp),
		.send_resp (send_resp),
		.tx        (tx),
		.resp_sent (resp_sent)
	);

endmodule

`default_nettype wire

// ==== verif/tb_uart_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd;

	localparam int cpb = uart_cmd_pkg::clk_per_bit;	// clocks per serial bit
	localparam int frame_cyc = 10 * cpb;			// start, 8 data, stop
	localparam int min_vectors = 4;
	localparam logic [15:0] lfsr_seed = 16'd18768;

	logic clk;
	logic rst_n;
	logic rx;
	logic tx;
	logic [uart_cmd_pkg::byte_w-1:0] resp;
	logic send_resp;
	logic resp_sent;
	logic clr_cmd_rdy;
	logic cmd_rdy;
	logic [uart_cmd_pkg::byte_w-1:0] cmd;
	logic [uart_cmd_pkg::param_w-1:0] data;

	// one entry per vector line
	logic [7:0] vec_op[$];
	logic [15:0] vec_par[$];
	logic [7:0] vec_resp[$];
	logic vec_clr[$];

	logic [15:0] lfsr;	// gap generator state
	int err_cnt;
	int chk_cnt;
	int test_cnt;
	int bad_tests;

	uart_cmd_top dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx          (rx),
		.tx          (tx),
		.resp        (resp),
		.send_resp   (send_resp),
		.resp_sent   (resp_sent),
		.clr_cmd_rdy (clr_cmd_rdy),
		.cmd_rdy     (cmd_rdy),
		.cmd         (cmd),
		.data        (data)
	);

	always #10 clk = ~clk;	// 20 ns period

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hb400;	// taps 16,14,13,11
		return s >> 1;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		chk_cnt++;
		assert (act === exp) else begin
			$display("Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic report_counts();
		$display("tests %0d, failing tests %0d, checks %0d, errors %0d",
			test_cnt, bad_tests, chk_cnt, err_cnt);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		report_counts();
		$display("Test failed");
		$finish;
	endtask

	task automatic end_test(input string name, input int start_err);
		test_cnt++;
		if (err_cnt > start_err) begin
			bad_tests++;
			$display("%s: %0d errors", name, err_cnt - start_err);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		int bad_cols;
		string line;
		string bad_line;
		logic [7:0] op;
		logic [15:0] par;
		logic [7:0] rsp;
		logic [3:0] clr;
		fd = $fopen("verif/cmd_input.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open the vector file verif/cmd_input.txt");
		end else begin
			bad_cols = 0;
			bad_line = "";
			while (!$feof(fd) && bad_cols == 0) begin
				line = "";
				n = $fgets(line, fd);
				n = $sscanf(line, "%h %h %h %h", op, par, rsp, clr);	// comments give 0
				if (n == 4) begin
					vec_op.push_back(op);
					vec_par.push_back(par);
					vec_resp.push_back(rsp);
					vec_clr.push_back(clr != 4'd0);
				end else if (n > 0) begin
					bad_cols = n;
					bad_line = line;
				end
			end
			$fclose(fd);
			if (bad_cols > 0)
				abort_run($sformatf("vector file line has %0d of 4 columns: %s",
					bad_cols, bad_line));
			else if (vec_op.size() < min_vectors)
				abort_run($sformatf("vector file holds %0d vectors, at least %0d are needed",
					vec_op.size(), min_vectors));
		end
	endtask

	// 0 to 15 idle bit periods with one lfsr step per bit
	task automatic idle_gap();
		int g;
		g = 0;
		repeat (4) begin
			lfsr = lfsr_next(lfsr);
			g = (g << 1) | int'(lfsr[0]);
		end
		repeat (g * cpb) @(posedge clk);
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frm;
		frm = {1'b1, b, 1'b0};	// stop, data, start
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rx <= frm[i];
			repeat (cpb - 1) @(posedge clk);
		end
	endtask

	task automatic wait_cmd_rdy(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (cmd_rdy !== 1'b1 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (cmd_rdy !== 1'b1)
			abort_run($sformatf("timeout: cmd_rdy did not rise within %0d cycles", limit));
	endtask

	// decode one frame from tx by sampling each bit at its middle
	task automatic recv_byte(output logic [7:0] b);
		int n;
		n = 0;
		b = '0;
		@(negedge clk);
		while (tx !== 1'b0 && n < 2 * frame_cyc) begin
			@(negedge clk);
			n++;
		end
		if (tx !== 1'b0) begin
			abort_run("timeout: no start bit appeared on tx");
		end else begin
			repeat (cpb / 2) @(negedge clk);
			check_val("tx start bit", 32'd0, 32'(tx));
			for (int i = 0; i < 8; i++) begin
				repeat (cpb) @(negedge clk);
				b[i] = tx;	// lsb first
				check_val("resp_sent during frame", 32'd0, 32'(resp_sent));
			end
			repeat (cpb) @(negedge clk);
			check_val("tx stop bit", 32'd1, 32'(tx));
			check_val("resp_sent in stop bit", 32'd0, 32'(resp_sent));
			n = 0;
			while (resp_sent !== 1'b1 && n < cpb) begin
				@(negedge clk);
				n++;
			end
			if (resp_sent !== 1'b1)
				abort_run("timeout: resp_sent did not rise after the stop bit");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int start_err;
		logic prev_clr;
		logic saw_low;
		logic [7:0] got;
		clk = 1'b0;
		rst_n = 1'b0;
		rx = 1'b1;	// idle line
		resp = '0;
		send_resp = 1'b0;
		clr_cmd_rdy = 1'b0;
		lfsr = lfsr_seed;
		err_cnt = 0;
		chk_cnt = 0;
		test_cnt = 0;
		bad_tests = 0;
		load_vectors();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		start_err = err_cnt;
		check_val("tx", 32'd1, 32'(tx));
		check_val("cmd_rdy", 32'd0, 32'(cmd_rdy));
		check_val("resp_sent", 32'd0, 32'(resp_sent));
		end_test("reset values", start_err);

		prev_clr = 1'b1;	// nothing pending before the first command
		for (int v = 0; v < vec_op.size(); v++) begin
			start_err = err_cnt;
			@(negedge clk);
			// an uncleared command stays flagged until the next opcode lands
			check_val("cmd_rdy before command", prev_clr ? 32'd0 : 32'd1, 32'(cmd_rdy));
			send_byte(vec_op[v]);
			idle_gap();
			send_byte(vec_par[v][15:8]);
			idle_gap();
			@(negedge clk);
			check_val("cmd_rdy before third byte", 32'd0, 32'(cmd_rdy));
			send_byte(vec_par[v][7:0]);
			wait_cmd_rdy(4 * cpb);
			check_val("cmd", 32'(vec_op[v]), 32'(cmd));
			check_val("data", 32'(vec_par[v]), 32'(data));
			if (vec_clr[v]) begin
				@(posedge clk);
				clr_cmd_rdy <= 1'b1;
				@(posedge clk);
				clr_cmd_rdy <= 1'b0;
				@(negedge clk);
				check_val("cmd_rdy after clear", 32'd0, 32'(cmd_rdy));
				check_val("cmd after clear", 32'(vec_op[v]), 32'(cmd));
				check_val("data after clear", 32'(vec_par[v]), 32'(data));
			end
			prev_clr = vec_clr[v];
			@(posedge clk);
			resp <= vec_resp[v];
			send_resp <= 1'b1;
			@(posedge clk);
			send_resp <= 1'b0;
			recv_byte(got);
			check_val("tx byte", 32'(vec_resp[v]), 32'(got));
			end_test($sformatf("vector %0d", v), start_err);
		end

		// second strobe lands in the middle of a frame
		start_err = err_cnt;
		@(posedge clk);
		resp <= vec_resp[0];
		send_resp <= 1'b1;
		@(posedge clk);
		send_resp <= 1'b0;
		fork
			recv_byte(got);
			begin
				repeat (5 * cpb) @(posedge clk);
				resp <= ~vec_resp[0];
				send_resp <= 1'b1;
				@(posedge clk);
				send_resp <= 1'b0;
			end
		join
		check_val("tx byte with busy send_resp", 32'(vec_resp[0]), 32'(got));
		saw_low = 1'b0;
		repeat (2 * frame_cyc) begin
			@(negedge clk);
			if (tx == 1'b0)
				saw_low = 1'b1;
		end
		chk_cnt++;
		assert (!saw_low) else begin
			$display("a second frame started on tx after a send_resp that came while busy");
			err_cnt++;
		end
		end_test("send_resp while busy", start_err);

		report_counts();
		if (err_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
logic/uart_cmd_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/cmd_assembler.sv
logic/uart_cmd_top.sv
verif/tb_uart_cmd.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the serial command testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f build.f \
	--top-module tb_uart_cmd -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/Vtb_uart_cmd > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

cat sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without a failure"
exit 0

// ==== verif/cmd_input.txt ====
# columns in hex: opcode  parameter  response  clear
# clear is 1 to pulse clr_cmd_rdy after the command, 0 to leave cmd_rdy set
a5 1234 5a 1
00 0000 ff 1
ff ffff 00 0
3c 55aa c3 1
81 aa55 7e 0
12 8001 01 0
7f 00ff 80 1
c0 ff00 3f 1
01 0001 fe 0
e7 1ee7 18 1
5a a5a5 a5 0
99 6666 66 1
20 0200 d4 1
d4 beef 2b 0
6b cafe 94 0
0f f00f f0 1
b2 4d2b 4d 1
44 7531 bb 0
